/* tb/axi_wr_stats_stimulus.txt */
# A len size | a | W strb | w strb | B | C | I n | R, then 13 E lines
# A and I are decimal, W, w and E are hex; E gives stat ids 0 to 12 in order
R
E 0
E 0
E ffffffff
E 0
E 0
E 0
E ffffffff
E 0
E 0
E 0
E ffffffff
E 0
E 0
# mixed bursts, four outstanding before any response
A 3 2
a
A 0 0
A 7 1
A 15 2
W f
W 1
w f
W 3
I 2
W 8
W 6
B
B
B
A 1 3
B
B
R
E 5
E 1f
E 1
E 10
E 5
E 71
E 1
E 40
E 5
E a
E 1
E 4
E 4
# clear, then write beats only
C
W 7
w 3
W 2
W 5
R
E 0
E 0
E ffffffff
E 0
E 0
E 0
E ffffffff
E 0
E 3
E 6
E 1
E 3
E 0

/* project.f */
+incdir+rtl
rtl/axi_wr_stats_pkg.sv
rtl/axi_wr_event_decode.sv
rtl/stat_accum.sv
rtl/stat_iter.sv
rtl/axi_wr_stats.sv
tb/tb_axi_wr_stats.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/1ns -Wno-fatal \
  --top-module tb_axi_wr_stats \
  -f project.f \
  -o sim_tb_axi_wr_stats
./obj_dir/sim_tb_axi_wr_stats

/* tb/tb_axi_wr_stats.sv */
`timescale 1ns/1ns
`default_nettype none

`include "axi_wr_stats_consts.svh"

module tb_axi_wr_stats
  import axi_wr_stats_pkg::*;
();

  localparam int          CLK_PERIOD   = 40;
  localparam int          RESET_CYCLES = 4;
  localparam logic [31:0] SEED         = 32'hdcc2_767b;
  localparam string       STIM_FILE    = "tb/axi_wr_stats_stimulus.txt";

  logic                   clk;
  logic                   rst_n;
  logic                   stat_clear;
  logic                   awvalid;
  logic                   awready;
  logic [ `LEN_WIDTH-1:0] awlen;
  logic [`SIZE_WIDTH-1:0] awsize;
  logic                   wvalid;
  logic                   wready;
  logic [`STRB_WIDTH-1:0] wstrb;
  logic                   bvalid;
  logic                   bready;
  logic                   stat_iter_start;
  logic                   stat_iter_ready;
  logic                   stat_iter_valid;
  stat_id_t               stat_iter_id;
  stat_word_t             stat_iter_val;
  logic                   stat_iter_last;

  int                     cycles;
  int                     cycle_limit;
  logic [31:0]            rnd_state;
  stat_word_t             expected [`NUM_STATS];

  axi_wr_stats i_axi_wr_stats (
    .clk             (clk),
    .rst_n           (rst_n),
    .stat_clear      (stat_clear),
    .awvalid         (awvalid),
    .awready         (awready),
    .awlen           (awlen),
    .awsize          (awsize),
    .wvalid          (wvalid),
    .wready          (wready),
    .wstrb           (wstrb),
    .bvalid          (bvalid),
    .bready          (bready),
    .stat_iter_start (stat_iter_start),
    .stat_iter_valid (stat_iter_valid),
    .stat_iter_id    (stat_iter_id),
    .stat_iter_val   (stat_iter_val),
    .stat_iter_last  (stat_iter_last),
    .stat_iter_ready (stat_iter_ready)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // run length bound, set once the stimulus file has been sized
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("timeout: the test did not finish within %0d cycles", cycle_limit);
      $display("SIMULATION FAILED");
      $fatal(1, "timeout");
    end
  end

  function automatic logic [31:0] next_random(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $fatal(1, "%s", why);
  endtask

  task automatic check_value(input string name, input stat_word_t exp, input stat_word_t act);
    if (exp !== act) begin
      $display("ERR %s expected %0h actual %0h", name, exp, act);
      $display("SIMULATION FAILED");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  task automatic idle_inputs();
    stat_clear      = 1'b0;
    awvalid         = 1'b0;
    awready         = 1'b0;
    awlen           = '0;
    awsize          = '0;
    wvalid          = 1'b0;
    wready          = 1'b0;
    wstrb           = '0;
    bvalid          = 1'b0;
    bready          = 1'b0;
    stat_iter_start = 1'b0;
    stat_iter_ready = 1'b0;
  endtask

  // hold the driven values for one cycle, then release them
  task automatic end_cycle();
    @(negedge clk);
    idle_inputs();
  endtask

  task automatic open_stimulus(output int fd);
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      abort_run({"could not open the stimulus file ", STIM_FILE});
    end
  endtask

  task automatic size_stimulus(output int lines, output int reads);
    int    fd;
    string line;
    lines = 0;
    reads = 0;
    open_stimulus(fd);
    while ($fgets(line, fd) > 0) begin
      lines++;
      if (line[0] == "R") begin
        reads++;
      end
    end
    $fclose(fd);
  endtask

  task automatic load_expected(input int fd);
    string       line;
    logic [31:0] v;
    for (int i = 0; i < `NUM_STATS; i++) begin
      if ($fgets(line, fd) == 0 || line[0] != "E") begin
        abort_run("a stat read is not followed by its expected values");
      end
      void'($sscanf(line.substr(1, line.len() - 1), "%h", v));
      expected[i] = v;
    end
  endtask

  // drain all stats with random back-pressure on ready
  task automatic read_stats(input string name);
    int         got;
    logic       held;
    stat_id_t   held_id;
    stat_word_t held_val;
    logic       held_last;
    got  = 0;
    held = 1'b0;
    repeat (3) @(negedge clk);
    stat_iter_start = 1'b1;
    @(negedge clk);
    stat_iter_start = 1'b0;
    while (got < `NUM_STATS) begin
      if (held) begin
        check_value({name, " held valid"}, 1, stat_iter_valid);
        check_value({name, " held id"}, held_id, stat_iter_id);
        check_value({name, " held value"}, held_val, stat_iter_val);
        check_value({name, " held last"}, held_last, stat_iter_last);
      end
      rnd_state       = next_random(rnd_state);
      stat_iter_ready = (rnd_state[1:0] != 2'b00);
      if (stat_iter_valid && stat_iter_ready) begin
        check_value($sformatf("%s id", name), stat_word_t'(got), stat_iter_id);
        check_value($sformatf("%s last at %0d", name, got), (got == `NUM_STATS - 1),
                    stat_iter_last);
        check_value($sformatf("%s stat %0d", name, got), expected[got], stat_iter_val);
        got++;
        held = 1'b0;
      end else begin
        held      = stat_iter_valid;
        held_id   = stat_iter_id;
        held_val  = stat_iter_val;
        held_last = stat_iter_last;
      end
      @(negedge clk);
    end
    stat_iter_ready = 1'b0;
    // no fourteenth word
    check_value({name, " valid after last"}, 0, stat_iter_valid);
  endtask

  initial begin
    int          fd;
    int          lines;
    int          reads;
    int          reads_done;
    string       line;
    string       args;
    byte         op;
    logic [31:0] a;
    logic [31:0] b;

    clk         = 1'b0;
    rst_n       = 1'b0;
    cycles      = 0;
    cycle_limit = 0;
    reads_done  = 0;
    rnd_state   = SEED;
    idle_inputs();

    size_stimulus(lines, reads);
    cycle_limit = 40 * lines + 200 * reads;

    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;

    open_stimulus(fd);
    while ($fgets(line, fd) > 0) begin
      if (line.len() < 1 || line[0] == "#" || line[0] == "\n") begin
        continue;
      end
      op   = line[0];
      args = line.substr(1, line.len() - 1);
      case (op)
        "A": begin
          void'($sscanf(args, "%d %d", a, b));
          awvalid = 1'b1;
          awready = 1'b1;
          awlen   = a[`LEN_WIDTH-1:0];
          awsize  = b[`SIZE_WIDTH-1:0];
          end_cycle();
        end
        "a": begin
          awvalid = 1'b1;
          awlen   = 8'h55;
          awsize  = 3'd2;
          end_cycle();
        end
        "W", "w": begin
          void'($sscanf(args, "%h", a));
          wvalid = 1'b1;
          wready = (op == "W");
          wstrb  = a[`STRB_WIDTH-1:0];
          end_cycle();
        end
        "B": begin
          bvalid = 1'b1;
          bready = 1'b1;
          end_cycle();
        end
        "C": begin
          stat_clear = 1'b1;
          end_cycle();
        end
        "I": begin
          void'($sscanf(args, "%d", a));
          repeat (a) @(negedge clk);
        end
        "R": begin
          load_expected(fd);
          reads_done++;
          read_stats($sformatf("read %0d", reads_done));
        end
        default: begin
          abort_run({"unknown line in the stimulus file: ", line});
        end
      endcase
    end
    $fclose(fd);

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* rtl/axi_wr_stats.sv */
`timescale 1ns/1ns
`default_nettype none

`include "axi_wr_stats_consts.svh"

module axi_wr_stats
  import axi_wr_stats_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    stat_clear,

  input  logic                    awvalid,
  input  logic                    awready,
  input  logic [ `LEN_WIDTH-1:0]  awlen,
  input  logic [`SIZE_WIDTH-1:0]  awsize,
  input  logic                    wvalid,
  input  logic                    wready,
  input  logic [`STRB_WIDTH-1:0]  wstrb,
  input  logic                    bvalid,
  input  logic                    bready,

  input  logic                    stat_iter_start,
  output logic                    stat_iter_valid,
  output stat_id_t                stat_iter_id,
  output stat_word_t              stat_iter_val,
  output logic                    stat_iter_last,
  input  logic                    stat_iter_ready
);

  logic [`NUM_CHAN-1:0] sample_en;
  stat_word_t           sample_val [`NUM_CHAN];

  stat_word_t           chan_count [`NUM_CHAN];
  stat_word_t           chan_sum   [`NUM_CHAN];
  stat_word_t           chan_min   [`NUM_CHAN];
  stat_word_t           chan_max   [`NUM_CHAN];
  stat_word_t           depth_max;

  axi_wr_event_decode i_axi_wr_event_decode (
    .clk        (clk),
    .rst_n      (rst_n),
    .stat_clear (stat_clear),
    .awvalid    (awvalid),
    .awready    (awready),
    .awlen      (awlen),
    .awsize     (awsize),
    .wvalid     (wvalid),
    .wready     (wready),
    .wstrb      (wstrb),
    .bvalid     (bvalid),
    .bready     (bready),
    .sample_en  (sample_en),
    .sample_val (sample_val),
    .depth_max  (depth_max)
  );

  // one accumulator per sample stream, indexed like chan_t
  for (genvar c = 0; c < `NUM_CHAN; c++) begin : g_accum
    stat_accum i_stat_accum (
      .clk        (clk),
      .rst_n      (rst_n),
      .clear      (stat_clear),
      .sample_en  (sample_en[c]),
      .sample_val (sample_val[c]),
      .count      (chan_count[c]),
      .sum        (chan_sum[c]),
      .min        (chan_min[c]),
      .max        (chan_max[c])
    );
  end

  stat_iter i_stat_iter (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (stat_iter_start),
    .ready      (stat_iter_ready),
    .chan_count (chan_count),
    .chan_sum   (chan_sum),
    .chan_min   (chan_min),
    .chan_max   (chan_max),
    .depth_max  (depth_max),
    .valid      (stat_iter_valid),
    .id         (stat_iter_id),
    .val        (stat_iter_val),
    .last       (stat_iter_last)
  );

endmodule

`default_nettype wire

/* rtl/stat_iter.sv */
`timescale 1ns/1ns
`default_nettype none

`include "axi_wr_stats_consts.svh"

module stat_iter
  import axi_wr_stats_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       start,
  input  logic       ready,

  input  stat_word_t chan_count [`NUM_CHAN],
  input  stat_word_t chan_sum   [`NUM_CHAN],
  input  stat_word_t chan_min   [`NUM_CHAN],
  input  stat_word_t chan_max   [`NUM_CHAN],
  input  stat_word_t depth_max,

  output logic       valid,
  output stat_id_t   id,
  output stat_word_t val,
  output logic       last
);

  typedef enum logic {
    ST_IDLE,
    ST_ITER
  } state_t;

  state_t                    state;
  state_t                    state_next;

  logic [`STAT_ID_WIDTH-1:0] idx;
  logic [`STAT_ID_WIDTH-1:0] idx_next;
  logic [`STAT_ID_WIDTH-1:0] load_idx;

  chan_t                     load_chan;
  stat_word_t                load_val;
  logic                      load_last;
  logic                      load;
  logic                      valid_next;

  // the word for load_idx, read live from the accumulators
  always_comb begin
    load_idx  = (state == ST_IDLE) ? '0 : idx;
    load_chan = chan_t'(load_idx[3:2]);
    load_last = (load_idx == `STAT_ID_WIDTH'(`NUM_STATS - 1));

    if (load_last) begin
      load_val = depth_max;
    end else begin
      case (load_idx[1:0])
        2'd0:    load_val = chan_count[load_chan];
        2'd1:    load_val = chan_sum[load_chan];
        2'd2:    load_val = chan_min[load_chan];
        default: load_val = chan_max[load_chan];
      endcase
    end
  end

  always_comb begin
    state_next = state;
    idx_next   = idx;
    load       = 1'b0;
    valid_next = valid && !ready;

    case (state)
      ST_IDLE: begin
        // first word goes out on the next cycle
        if (start) begin
          load       = 1'b1;
          state_next = ST_ITER;
        end
      end

      ST_ITER: begin
        if (valid && ready && last) begin
          state_next = ST_IDLE;
        end else if (!valid || ready) begin
          load = 1'b1;
        end
      end

      default: begin
        state_next = ST_IDLE;
      end
    endcase

    if (load) begin
      valid_next = 1'b1;
      idx_next   = load_idx + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= ST_IDLE;
      valid <= 1'b0;
      idx   <= '0;
    end else begin
      state <= state_next;
      valid <= valid_next;
      idx   <= idx_next;
    end
  end

  // held while the consumer stalls
  always_ff @(posedge clk) begin
    if (load) begin
      id   <= stat_id_t'(load_idx);
      val  <= load_val;
      last <= load_last;
    end
  end

endmodule

`default_nettype wire

/* rtl/stat_accum.sv */
`timescale 1ns/1ns
`default_nettype none

module stat_accum
  import axi_wr_stats_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       clear,

  input  logic       sample_en,
  input  stat_word_t sample_val,

  output stat_word_t count,
  output stat_word_t sum,
  output stat_word_t min,
  output stat_word_t max
);

  always_ff @(posedge clk) begin
    if (!rst_n || clear) begin
      count <= '0;
      sum   <= '0;
    end else if (sample_en) begin
      // both wrap at the word width
      count <= count + stat_word_t'(1);
      sum   <= sum + sample_val;
    end
  end

  // min starts at all ones so the first sample always lands
  always_ff @(posedge clk) begin
    if (!rst_n || clear) begin
      min <= '1;
    end else if (sample_en && (sample_val < min)) begin
      min <= sample_val;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n || clear) begin
      max <= '0;
    end else if (sample_en && (sample_val > max)) begin
      max <= sample_val;
    end
  end

endmodule

`default_nettype wire

/* rtl/axi_wr_event_decode.sv */
`timescale 1ns/1ns
`default_nettype none

`include "axi_wr_stats_consts.svh"

module axi_wr_event_decode
  import axi_wr_stats_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    stat_clear,

  input  logic                    awvalid,
  input  logic                    awready,
  input  logic [ `LEN_WIDTH-1:0]  awlen,
  input  logic [`SIZE_WIDTH-1:0]  awsize,
  input  logic                    wvalid,
  input  logic                    wready,
  input  logic [`STRB_WIDTH-1:0]  wstrb,
  input  logic                    bvalid,
  input  logic                    bready,

  output logic [  `NUM_CHAN-1:0]  sample_en,
  output stat_word_t              sample_val [`NUM_CHAN],
  output stat_word_t              depth_max
);

  logic                    aw_hs;
  logic                    w_hs;
  logic                    b_hs;

  stat_word_t              aw_beats;
  stat_word_t              aw_bytes;
  stat_word_t              w_bytes;

  logic [`DEPTH_WIDTH-1:0] depth;
  logic [`DEPTH_WIDTH-1:0] depth_peak;

  assign aw_hs = awvalid && awready;
  assign w_hs  = wvalid && wready;
  assign b_hs  = bvalid && bready;

  // awlen is beats minus one
  assign aw_beats = stat_word_t'(awlen) + stat_word_t'(1);
  assign aw_bytes = aw_beats << awsize;

  // bytes written by this beat
  always_comb begin
    w_bytes = '0;
    for (int i = 0; i < `STRB_WIDTH; i++) begin
      w_bytes = w_bytes + stat_word_t'(wstrb[i]);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sample_en <= '0;
    end else begin
      sample_en[CHAN_AW_LEN]   <= aw_hs;
      sample_en[CHAN_AW_BYTES] <= aw_hs;
      sample_en[CHAN_W_BYTES]  <= w_hs;
    end
  end

  always_ff @(posedge clk) begin
    sample_val[CHAN_AW_LEN]   <= aw_beats;
    sample_val[CHAN_AW_BYTES] <= aw_bytes;
    sample_val[CHAN_W_BYTES]  <= w_bytes;
  end

  // bursts accepted on AW and not yet answered on B
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      depth <= '0;
    end else begin
      case ({aw_hs, b_hs})
        2'b10:   depth <= depth + 1'b1;
        2'b01:   depth <= depth - 1'b1;
        default: depth <= depth;
      endcase
    end
  end

  // the live depth follows the bus, only the peak is cleared
  always_ff @(posedge clk) begin
    if (!rst_n || stat_clear) begin
      depth_peak <= '0;
    end else if (depth > depth_peak) begin
      depth_peak <= depth;
    end
  end

  assign depth_max = stat_word_t'(depth_peak);

endmodule

`default_nettype wire

/* rtl/axi_wr_stats_pkg.sv */
`default_nettype none

`include "axi_wr_stats_consts.svh"

package axi_wr_stats_pkg;

  typedef logic [`STAT_WIDTH-1:0] stat_word_t;

  // sample streams, also the index into the accumulator array
  typedef enum logic [$clog2(`NUM_CHAN)-1:0] {
    CHAN_AW_LEN   = 0,
    CHAN_AW_BYTES = 1,
    CHAN_W_BYTES  = 2
  } chan_t;

  // per channel the order is count, sum, min, max
  typedef enum logic [`STAT_ID_WIDTH-1:0] {
    STAT_AW_LEN_CNT   = 0,
    STAT_AW_LEN_SUM   = 1,
    STAT_AW_LEN_MIN   = 2,
    STAT_AW_LEN_MAX   = 3,
    STAT_AW_BYTES_CNT = 4,
    STAT_AW_BYTES_SUM = 5,
    STAT_AW_BYTES_MIN = 6,
    STAT_AW_BYTES_MAX = 7,
    STAT_W_BYTES_CNT  = 8,
    STAT_W_BYTES_SUM  = 9,
    STAT_W_BYTES_MIN  = 10,
    STAT_W_BYTES_MAX  = 11,
    STAT_AW_DEPTH_MAX = 12
  } stat_id_t;

endpackage

`default_nettype wire

/* rtl/axi_wr_stats_consts.svh */
`ifndef AXI_WR_STATS_CONSTS_SVH
`define AXI_WR_STATS_CONSTS_SVH

// every statistic is carried in one word of this width
`define STAT_WIDTH 32

// write bus geometry, 32-bit data
`define STRB_WIDTH 4
`define LEN_WIDTH 8
`define SIZE_WIDTH 3

// outstanding AW-to-B counter
`define DEPTH_WIDTH 8

// three sample streams, four stats each, plus the depth maximum
`define NUM_CHAN 3
`define NUM_STATS 13
`define STAT_ID_WIDTH 8

`endif
